// File: rtl/dac_sample_pkg.sv
// Sample formats of the DAC path; all samples are signed two's complement, full scale +-2^17
package dac_sample_pkg;

    // ----------------------------------------
    // Sample format
    // ----------------------------------------

    // One audio sample
    localparam int SAMPLE_W = 18;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // ----------------------------------------
    // Stereo frame
    // ----------------------------------------

    // Left channel sits in the upper half, 36 bits in total
    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_frame_t;

endpackage

// File: rtl/dac_ctrl_pkg.sv
// Sequencer program and half-band coefficients; the program is fixed and holds at most 8 steps
package dac_ctrl_pkg;

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------

    // One-hot task codes
    typedef enum logic [4:0] {
        WAIT_IN          = 5'b00001,
        WAIT_DONE        = 5'b00010,
        SEND_1_2         = 5'b00100,
        SEND_2_DAC_CHECK = 5'b01000,
        JP_0             = 5'b10000
    } task_t;

    localparam int PC_W     = 3;
    localparam int PROG_LEN = 7;

    // Input, stage 1, two frames through stage 2, back to start
    localparam task_t PROGRAM [PROG_LEN] = '{
        WAIT_IN, WAIT_DONE, SEND_1_2, WAIT_DONE, SEND_1_2, WAIT_DONE, JP_0
    };

    // ----------------------------------------
    // Half-band filter
    // ----------------------------------------

    localparam int COEF_W = 18;

    typedef logic signed [COEF_W-1:0] coef_t;

    // Odd phase taps in Q1.16: -1/16, 9/16, 9/16, -1/16
    localparam coef_t HB_COEF [4] = '{-18'sd4096, 18'sd36864, 18'sd36864, -18'sd4096};

endpackage

// File: rtl/frame_fifo.sv
// Write when full and read when empty are dropped; data_out is valid the cycle after rd
`timescale 1ns/100ps

module frame_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wr,
    input  logic                                rd,
    input  dac_sample_pkg::stereo_frame_t       data_in,
    output dac_sample_pkg::stereo_frame_t       data_out,
    output logic                                empty,
    output logic                                full,
    output logic [$clog2(FIFO_DEPTH + 1)-1:0]   free_slots
);
    import dac_sample_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    stereo_frame_t    mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        next_ptr = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr      = wr && !full;
    assign do_rd      = rd && !empty;
    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(FIFO_DEPTH));
    assign free_slots = CNT_W'(FIFO_DEPTH) - count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            data_out <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_rd) begin
                rd_ptr   <= next_ptr(rd_ptr);
                data_out <= mem[rd_ptr];
            end
            // Simultaneous read and write keeps the count
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= data_in;
    end

endmodule

// File: rtl/halfband_interp_2x.sv
// New input is taken only while idle; even output 1 cycle and odd output 6 cycles after start
`timescale 1ns/100ps

module halfband_interp_2x (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_in_rdy,
    input  dac_sample_pkg::sample_t sample_in_l,
    input  dac_sample_pkg::sample_t sample_in_r,
    output logic                    sample_out_rdy,
    output dac_sample_pkg::sample_t sample_out_l,
    output dac_sample_pkg::sample_t sample_out_r,
    output logic                    done
);
    import dac_sample_pkg::*;
    import dac_ctrl_pkg::*;

    localparam int PROD_W = SAMPLE_W + COEF_W;
    localparam int ACC_W  = PROD_W + 2;
    // Q1.16 coefficients
    localparam int FRAC_W = COEF_W - 2;

    localparam logic signed [ACC_W-1:0] ROUND_HALF = ACC_W'(1) << (FRAC_W - 1);
    localparam logic signed [ACC_W-1:0] SAT_MAX    = (ACC_W'(1) << (SAMPLE_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN    = -(ACC_W'(1) << (SAMPLE_W - 1));

    localparam logic [2:0] PH_IDLE = 3'd0;
    localparam logic [2:0] PH_OUT  = 3'd5;

    sample_t                  x_in [2];
    sample_t                  hist [2][4];
    sample_t                  y    [2];
    logic signed [PROD_W-1:0] prod [2];
    logic signed [ACC_W-1:0]  acc  [2];
    logic [2:0]               phase;
    logic [1:0]               tap;
    logic                     start;

    function automatic sample_t round_sat(input logic signed [ACC_W-1:0] a);
        logic signed [ACC_W-1:0] r;
        r = (a + ROUND_HALF) >>> FRAC_W;
        if (r > SAT_MAX)
            round_sat = SAT_MAX[SAMPLE_W-1:0];
        else if (r < SAT_MIN)
            round_sat = SAT_MIN[SAMPLE_W-1:0];
        else
            round_sat = r[SAMPLE_W-1:0];
    endfunction

    assign x_in[0]      = sample_in_l;
    assign x_in[1]      = sample_in_r;
    assign sample_out_l = y[0];
    assign sample_out_r = y[1];
    assign start        = sample_in_rdy && (phase == PH_IDLE);
    // Phases 1 to 4 walk the taps
    assign tap          = 2'(phase - 3'd1);

    always_comb begin
        for (int ch = 0; ch < 2; ch++)
            prod[ch] = hist[ch][tap] * HB_COEF[tap];
    end

    // ----------------------------------------
    // Control and history
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase          <= PH_IDLE;
            sample_out_rdy <= 1'b0;
            done           <= 1'b0;
            for (int ch = 0; ch < 2; ch++)
                for (int k = 0; k < 4; k++)
                    hist[ch][k] <= '0;
        end else begin
            sample_out_rdy <= start || (phase == PH_OUT);
            done           <= (phase == PH_OUT);
            if (start) begin
                phase <= 3'd1;
                for (int ch = 0; ch < 2; ch++) begin
                    hist[ch][0] <= x_in[ch];
                    for (int k = 1; k < 4; k++)
                        hist[ch][k] <= hist[ch][k-1];
                end
            end else if (phase == PH_OUT) begin
                phase <= PH_IDLE;
            end else if (phase != PH_IDLE) begin
                phase <= phase + 3'd1;
            end
        end
    end

    // ----------------------------------------
    // MAC and output registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (start) begin
                // Even phase is the centre sample, two frames back after the shift
                y[ch]   <= hist[ch][1];
                acc[ch] <= '0;
            end else if (phase == PH_OUT) begin
                y[ch] <= round_sat(acc[ch]);
            end else if (phase != PH_IDLE) begin
                acc[ch] <= acc[ch] + prod[ch];
            end
        end
    end

endmodule

// File: rtl/sigma_delta_2order.sv
// Stable for inputs up to about half of full scale; integrators have no saturation
`timescale 1ns/100ps

module sigma_delta_2order (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_strobe,
    input  dac_sample_pkg::sample_t sample_l,
    input  dac_sample_pkg::sample_t sample_r,
    output logic                    dout_l,
    output logic                    dout_r
);
    import dac_sample_pkg::*;

    localparam int INT_W = 22;

    // Feedback level equals input full scale
    localparam logic signed [INT_W-1:0] FULL_SCALE = INT_W'(1) << (SAMPLE_W - 1);

    sample_t                 x        [2];
    logic signed [INT_W-1:0] fb       [2];
    logic signed [INT_W-1:0] int1     [2];
    logic signed [INT_W-1:0] int2     [2];
    logic signed [INT_W-1:0] int1_nxt [2];
    logic signed [INT_W-1:0] int2_nxt [2];
    logic                    dout_q   [2];

    assign x[0]   = sample_l;
    assign x[1]   = sample_r;
    assign dout_l = dout_q[0];
    assign dout_r = dout_q[1];

    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            fb[ch]       = dout_q[ch] ? FULL_SCALE : -FULL_SCALE;
            int1_nxt[ch] = int1[ch] + x[ch] - fb[ch];
            int2_nxt[ch] = int2[ch] + int1_nxt[ch] - fb[ch];
        end
    end

    // ----------------------------------------
    // Loop state, advanced once per strobe
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int ch = 0; ch < 2; ch++) begin
                int1[ch]   <= '0;
                int2[ch]   <= '0;
                dout_q[ch] <= 1'b0;
            end
        end else if (sample_strobe) begin
            for (int ch = 0; ch < 2; ch++) begin
                int1[ch]   <= int1_nxt[ch];
                int2[ch]   <= int2_nxt[ch];
                // One when the second integrator is not negative
                dout_q[ch] <= !int2_nxt[ch][INT_W-1];
            end
        end
    end

endmodule

// File: rtl/stereo_dac_output.sv
// Input is taken only while in_ready is high; the output rate is clk / OUT_CLK_DIV
`timescale 1ns/100ps

module stereo_dac_output #(
    parameter int OUT_CLK_DIV = 16,
    parameter int FIFO_DEPTH  = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_in_rdy,
    input  dac_sample_pkg::sample_t sample_in_l,
    input  dac_sample_pkg::sample_t sample_in_r,
    output logic                    in_ready,
    output logic                    dac_out_l,
    output logic                    dac_out_r,
    output logic                    dac_strobe,
    output logic                    dac_underrun
);
    import dac_sample_pkg::*;
    import dac_ctrl_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int DIV_W = (OUT_CLK_DIV > 1) ? $clog2(OUT_CLK_DIV) : 1;

    // Interpolator 2 emits two frames per start
    localparam logic [CNT_W-1:0] FRAME_PAIR = CNT_W'(2);

    task_t            tasks;
    logic [PC_W-1:0]  pc;
    logic             pc_hold;
    logic             pc_jump;
    logic             in_accept;
    logic             done;

    logic             i1_out_rdy;
    sample_t          i1_out_l;
    sample_t          i1_out_r;
    logic             i1_done;
    logic             i2_start;
    logic             i2_out_rdy;
    sample_t          i2_out_l;
    sample_t          i2_out_r;
    logic             i2_done;

    stereo_frame_t    fifo_1_2_data_in;
    stereo_frame_t    fifo_1_2_data_out;
    logic             fifo_1_2_rd;
    logic             fifo_1_2_empty;
    logic [CNT_W-1:0] fifo_1_2_free;
    stereo_frame_t    fifo_2_dac_data_in;
    stereo_frame_t    fifo_2_dac_data_out;
    logic             fifo_2_dac_rd;
    logic             fifo_2_dac_empty;
    logic [CNT_W-1:0] fifo_2_dac_free;
    logic             fifo_2_room;

    logic [DIV_W-1:0] div_cnt;
    logic             div_tick;

    // ----------------------------------------
    // Task sequencer
    // ----------------------------------------
    assign tasks       = (pc < PC_W'(PROG_LEN)) ? PROGRAM[pc] : JP_0;
    assign fifo_2_room = (fifo_2_dac_free >= FRAME_PAIR);
    assign in_ready    = (tasks == WAIT_IN) && (fifo_1_2_free >= FRAME_PAIR);
    assign in_accept   = sample_in_rdy && in_ready;
    assign done        = i1_done | i2_done;

    always_comb begin
        pc_hold = 1'b0;
        pc_jump = 1'b0;
        unique case (tasks)
            WAIT_IN:          pc_hold = !in_accept;
            WAIT_DONE:        pc_hold = !done;
            SEND_1_2:         pc_hold = !fifo_2_room || fifo_1_2_empty;
            SEND_2_DAC_CHECK: pc_hold = !fifo_2_room;
            default:          pc_jump = 1'b1;
        endcase
    end

    assign fifo_1_2_rd = (tasks == SEND_1_2) && !pc_hold;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= '0;
            i2_start <= 1'b0;
        end else begin
            // FIFO data is valid one cycle after the pop
            i2_start <= fifo_1_2_rd;
            if (pc_jump)
                pc <= '0;
            else if (!pc_hold)
                pc <= pc + PC_W'(1);
        end
    end

    // ----------------------------------------
    // Interpolation chain
    // ----------------------------------------
    halfband_interp_2x interp_1 (
        .clk            (clk),
        .reset          (reset),
        .sample_in_rdy  (in_accept),
        .sample_in_l    (sample_in_l),
        .sample_in_r    (sample_in_r),
        .sample_out_rdy (i1_out_rdy),
        .sample_out_l   (i1_out_l),
        .sample_out_r   (i1_out_r),
        .done           (i1_done)
    );

    assign fifo_1_2_data_in = {i1_out_l, i1_out_r};

    frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_1_2 (
        .clk        (clk),
        .reset      (reset),
        .wr         (i1_out_rdy),
        .rd         (fifo_1_2_rd),
        .data_in    (fifo_1_2_data_in),
        .data_out   (fifo_1_2_data_out),
        .empty      (fifo_1_2_empty),
        .full       (),
        .free_slots (fifo_1_2_free)
    );

    halfband_interp_2x interp_2 (
        .clk            (clk),
        .reset          (reset),
        .sample_in_rdy  (i2_start),
        .sample_in_l    (fifo_1_2_data_out.l),
        .sample_in_r    (fifo_1_2_data_out.r),
        .sample_out_rdy (i2_out_rdy),
        .sample_out_l   (i2_out_l),
        .sample_out_r   (i2_out_r),
        .done           (i2_done)
    );

    assign fifo_2_dac_data_in = {i2_out_l, i2_out_r};

    frame_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_2_dac (
        .clk        (clk),
        .reset      (reset),
        .wr         (i2_out_rdy),
        .rd         (fifo_2_dac_rd),
        .data_in    (fifo_2_dac_data_in),
        .data_out   (fifo_2_dac_data_out),
        .empty      (fifo_2_dac_empty),
        .full       (),
        .free_slots (fifo_2_dac_free)
    );

    // ----------------------------------------
    // Output rate divider
    // ----------------------------------------
    assign div_tick      = (div_cnt == DIV_W'(OUT_CLK_DIV - 1));
    assign fifo_2_dac_rd = div_tick && !fifo_2_dac_empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt      <= '0;
            dac_strobe   <= 1'b0;
            dac_underrun <= 1'b0;
        end else begin
            div_cnt      <= div_tick ? '0 : div_cnt + DIV_W'(1);
            dac_strobe   <= fifo_2_dac_rd;
            // Nothing to play, modulator reuses the last frame
            dac_underrun <= div_tick && fifo_2_dac_empty;
        end
    end

    sigma_delta_2order modulator (
        .clk           (clk),
        .reset         (reset),
        .sample_strobe (dac_strobe | dac_underrun),
        .sample_l      (fifo_2_dac_data_out.l),
        .sample_r      (fifo_2_dac_data_out.r),
        .dout_l        (dac_out_l),
        .dout_r        (dac_out_r)
    );

endmodule

// File: tb/stereo_dac_output_asserts.sv
// Bound into stereo_dac_output; needs --assert, and fail_count is read by the testbench
`timescale 1ns/100ps

module stereo_dac_output_asserts #(
    parameter int OUT_CLK_DIV = 16
) (
    input logic clk,
    input logic reset,
    input logic sample_in_rdy,
    input logic in_ready,
    input logic dac_out_l,
    input logic dac_out_r,
    input logic dac_strobe,
    input logic dac_underrun
);
    int unsigned fail_count = 0;
    int unsigned quiet_cycles;
    int unsigned accepted;
    int unsigned strobes;
    logic        update;

    assign update = dac_strobe || dac_underrun;

    // ----------------------------------------
    // Event spacing and frame bookkeeping
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            quiet_cycles <= OUT_CLK_DIV;
            accepted     <= 0;
            strobes      <= 0;
        end else begin
            if (update)
                quiet_cycles <= 0;
            else if (quiet_cycles < OUT_CLK_DIV)
                quiet_cycles <= quiet_cycles + 1;
            if (sample_in_rdy && in_ready)
                accepted <= accepted + 1;
            if (dac_strobe)
                strobes <= strobes + 1;
        end
    end

    // ----------------------------------------
    // Properties
    // ----------------------------------------
    reset_state: assert property (@(posedge clk)
        (reset || $past(reset)) |->
            (!dac_out_l && !dac_out_r && !dac_strobe && !dac_underrun && in_ready))
    else begin
        fail_count++;
        $error("ERROR dac_out_l=0x%h dac_out_r=0x%h dac_strobe=0x%h dac_underrun=0x%h in_ready=0x%h",
               dac_out_l, dac_out_r, dac_strobe, dac_underrun, in_ready);
    end

    strobe_or_underrun: assert property (@(posedge clk) disable iff (reset)
        !(dac_strobe && dac_underrun))
    else begin
        fail_count++;
        $error("ERROR dac_strobe=0x%h dac_underrun=0x%h", dac_strobe, dac_underrun);
    end

    update_spacing: assert property (@(posedge clk) disable iff (reset)
        update |-> (quiet_cycles >= OUT_CLK_DIV - 1))
    else begin
        fail_count++;
        $error("ERROR dac_strobe/dac_underrun quiet_cycles=0x%h", quiet_cycles);
    end

    // Output bits move only after a modulator update
    out_change: assert property (@(posedge clk) disable iff (reset)
        (!$stable(dac_out_l) || !$stable(dac_out_r)) |-> $past(update))
    else begin
        fail_count++;
        $error("ERROR dac_out_l=0x%h dac_out_r=0x%h changed without update",
               dac_out_l, dac_out_r);
    end

    in_ready_drop: assert property (@(posedge clk) disable iff (reset)
        $past(sample_in_rdy && in_ready, 2) |-> !(in_ready && $past(in_ready)))
    else begin
        fail_count++;
        $error("ERROR in_ready=0x%h still high after accept", in_ready);
    end

    strobe_bound: assert property (@(posedge clk) disable iff (reset)
        strobes <= 4 * accepted)
    else begin
        fail_count++;
        $error("ERROR dac_strobe count=0x%h frames accepted=0x%h", strobes, accepted);
    end

endmodule

bind stereo_dac_output stereo_dac_output_asserts #(
    .OUT_CLK_DIV (OUT_CLK_DIV)
) u_asserts (
    .clk           (clk),
    .reset         (reset),
    .sample_in_rdy (sample_in_rdy),
    .in_ready      (in_ready),
    .dac_out_l     (dac_out_l),
    .dac_out_r     (dac_out_r),
    .dac_strobe    (dac_strobe),
    .dac_underrun  (dac_underrun)
);

// File: tb/tb_stereo_dac_output.sv
// Needs Verilator --timing --assert; levels stay within half of full scale for a stable modulator
`timescale 1ns/100ps

module tb_stereo_dac_output;
    import dac_sample_pkg::*;

    localparam int OUT_CLK_DIV   = 16;
    localparam int FIFO_DEPTH    = 8;
    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 4;
    localparam int SEND_GAP      = 64;
    // Interpolator 1 is idle again while in_ready is still low
    localparam int STRAY_AT      = 10;
    localparam int SETTLE_FRAMES = 24;
    localparam int COUNT_LEN     = 256;
    localparam int COUNT_TOL     = 4;
    localparam int FULL_SCALE    = 1 << (SAMPLE_W - 1);
    localparam int WAIT_LIMIT    = 2000;

    logic    clk;
    logic    reset;
    logic    sample_in_rdy;
    sample_t sample_in_l;
    sample_t sample_in_r;
    logic    in_ready;
    logic    dac_out_l;
    logic    dac_out_r;
    logic    dac_strobe;
    logic    dac_underrun;

    logic    sending;
    sample_t level_l;
    sample_t level_r;
    int      frames_sent;

    stereo_dac_output #(
        .OUT_CLK_DIV (OUT_CLK_DIV),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) i_stereo_dac_output (
        .clk           (clk),
        .reset         (reset),
        .sample_in_rdy (sample_in_rdy),
        .sample_in_l   (sample_in_l),
        .sample_in_r   (sample_in_r),
        .in_ready      (in_ready),
        .dac_out_l     (dac_out_l),
        .dac_out_r     (dac_out_r),
        .dac_strobe    (dac_strobe),
        .dac_underrun  (dac_underrun)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // Ones count within tolerance of 256 * (x + 2^17) / 2^18
    function automatic bit density_ok(input int ones, input sample_t x);
        longint got;
        longint want;
        got  = longint'(ones) * (2 * FULL_SCALE);
        want = longint'(COUNT_LEN) * (longint'(x) + FULL_SCALE);
        density_ok = (got - want <= COUNT_TOL * 2 * FULL_SCALE) &&
                     (want - got <= COUNT_TOL * 2 * FULL_SCALE);
    endfunction

    function automatic int expected_ones(input sample_t x);
        expected_ones = (COUNT_LEN * (int'(x) + FULL_SCALE)) / (2 * FULL_SCALE);
    endfunction

    function automatic sample_t random_level();
        int v;
        v = int'($urandom_range(2 * FULL_SCALE / 2, 0)) - FULL_SCALE / 2;
        random_level = sample_t'(v);
    endfunction

    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = frames_sent + n;
        waited = 0;
        while (frames_sent < target) begin
            @(negedge clk);
            waited++;
            if (waited > n * SEND_GAP * 2 + WAIT_LIMIT)
                abort_run("timeout: input frames are not being accepted");
        end
    endtask

    task automatic wait_for_pulse(input bit want_underrun, input string what);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run({"timeout waiting for ", what});
        end while (want_underrun ? !dac_underrun : !dac_strobe);
    endtask

    task automatic measure_density(input sample_t x_l, input sample_t x_r);
        int ones_l;
        int ones_r;
        int n;
        int waited;
        ones_l = 0;
        ones_r = 0;
        n      = 0;
        waited = 0;
        while (n < COUNT_LEN) begin
            @(negedge clk);
            waited++;
            if (waited > 2 * COUNT_LEN * OUT_CLK_DIV)
                abort_run("timeout: modulator updates stopped during density count");
            if (dac_strobe || dac_underrun) begin
                n++;
                ones_l += int'(dac_out_l);
                ones_r += int'(dac_out_r);
            end
        end
        assert (density_ok(ones_l, x_l)) else begin
            $display("ERROR dac_out_l ones=0x%h expected=0x%h", ones_l, expected_ones(x_l));
            abort_run("left channel ones density out of range");
        end
        assert (density_ok(ones_r, x_r)) else begin
            $display("ERROR dac_out_r ones=0x%h expected=0x%h", ones_r, expected_ones(x_r));
            abort_run("right channel ones density out of range");
        end
    endtask

    // ----------------------------------------
    // Frame source with at most one frame per SEND_GAP
    // ----------------------------------------
    initial begin : feeder
        int since_send;
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;
        frames_sent   = 0;
        since_send    = 0;
        forever begin
            @(negedge clk);
            sample_in_rdy = 1'b0;
            if (since_send == STRAY_AT && !in_ready) begin
                // Ignored pulse with wrong data
                sample_in_rdy = 1'b1;
                sample_in_l   = ~level_l;
                sample_in_r   = ~level_r;
            end else if (!reset && sending && in_ready && since_send >= SEND_GAP) begin
                sample_in_rdy = 1'b1;
                sample_in_l   = level_l;
                sample_in_r   = level_r;
                since_send    = 0;
                frames_sent++;
            end
            since_send++;
        end
    end

    always @(negedge clk) begin
        if (i_stereo_dac_output.u_asserts.fail_count != 0)
            abort_run("a bound assertion failed");
    end

    // ----------------------------------------
    // Test phases
    // ----------------------------------------
    initial begin : main_flow
        void'($urandom(8889));
        reset   = 1'b1;
        sending = 1'b0;
        level_l = '0;
        level_r = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // DC at plus and minus half scale
        level_l = sample_t'(FULL_SCALE / 2);
        level_r = sample_t'(-(FULL_SCALE / 2));
        sending = 1'b1;
        wait_frames(SETTLE_FRAMES);
        measure_density(level_l, level_r);

        // Starve the output
        sending = 1'b0;
        wait_for_pulse(1'b1, "dac_underrun after input stopped");

        for (int i = 0; i < 2; i++) begin
            level_l = random_level();
            level_r = random_level();
            sending = 1'b1;
            wait_for_pulse(1'b0, "dac_strobe after input resumed");
            wait_frames(SETTLE_FRAMES);
            measure_density(level_l, level_r);
        end
        sending = 1'b0;
        @(negedge clk);

        if (i_stereo_dac_output.u_asserts.fail_count != 0) begin
            abort_run("bound assertions reported failures");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: tb.f
rtl/dac_sample_pkg.sv
rtl/dac_ctrl_pkg.sv
rtl/frame_fifo.sv
rtl/halfband_interp_2x.sv
rtl/sigma_delta_2order.sv
rtl/stereo_dac_output.sv
tb/stereo_dac_output_asserts.sv
tb/tb_stereo_dac_output.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stereo_dac_output \
    -f tb.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
